/* hw/cnn_types_pkg.sv */
package cnn_types_pkg;

  //////////////////////////////
  // Pixel payload
  //////////////////////////////

  // One feature-map value, fixed point
  localparam int PIXEL_WIDTH = 16;

  typedef logic [PIXEL_WIDTH-1:0] pixel_t;

  //////////////////////////////
  // Merged stream tagging
  //////////////////////////////

  // Origin of a pixel on the merged stream
  typedef enum logic {
    SRC_BRANCH1 = 1'b0,
    SRC_BRANCH2 = 1'b1
  } src_t;

endpackage

/* hw/cnn_geom_pkg.sv */
package cnn_geom_pkg;

  //////////////////////////////
  // Feature-map geometry
  //////////////////////////////

  // Pixels in one map of one branch
  // 8x8 spatial slice of one channel
  localparam int MAP_PIXELS_DEFAULT = 64;

  // Line buffers in the branch-1 chain
  // Map must split evenly across them
  localparam int DELAY_STAGES_DEFAULT = 4;

  // Top level may override both per instance

endpackage

/* hw/concat_stream_if.sv */
interface concat_stream_if;
  import cnn_types_pkg::*;

  // Pixel transferred this cycle
  logic   valid;
  pixel_t data;
  // Which branch the pixel came from
  src_t   src;
  // Branch-1 pixel lost to branch 2 this cycle
  logic   collision;

  // Merge side
  modport producer (
    output valid, data, src, collision
  );

  // Output register side
  modport consumer (
    input valid, data, src, collision
  );

endinterface

/* hw/line_buffer.sv */
module line_buffer #(
  parameter int DEPTH = 16
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  cnn_types_pkg::pixel_t data_in,
  output logic                  valid_out,
  output cnn_types_pkg::pixel_t data_out
);
  import cnn_types_pkg::*;

  localparam int FILL_W = $clog2(DEPTH + 1);

  // Storage, oldest pixel at the far end
  pixel_t            mem [DEPTH];
  logic [FILL_W-1:0] fill;
  logic              full;

  //////////////////////////////
  // Shift register
  //////////////////////////////

  // Advance only on valid input, idle cycles hold
  always_ff @(posedge clk) begin
    if (valid_in) begin
      mem[0] <= data_in;
      for (int i = 1; i < DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  //////////////////////////////
  // Fill tracking
  //////////////////////////////

  // Count valid inputs, stops at DEPTH
  always_ff @(posedge clk) begin
    if (reset) begin
      fill <= '0;
    end else if (valid_in && !full) begin
      fill <= fill + 1'b1;
    end
  end

  assign full = (fill == FILL_W'(DEPTH));

  // Pixel leaving as the new one enters
  assign valid_out = valid_in && full;
  assign data_out  = mem[DEPTH-1];

  // Output only ever moves together with an input
  a_out_needs_in : assert property (
    @(posedge clk) disable iff (reset) !valid_in |-> !valid_out
  );

endmodule

/* hw/cnn_concat_delay.sv */
module cnn_concat_delay #(
  parameter int MAP_PIXELS   = cnn_geom_pkg::MAP_PIXELS_DEFAULT,
  parameter int DELAY_STAGES = cnn_geom_pkg::DELAY_STAGES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  valid_in,
  input  cnn_types_pkg::pixel_t data_in,
  output logic                  valid_out,
  output cnn_types_pkg::pixel_t data_out
);
  import cnn_types_pkg::*;

  // Each stage holds an equal slice of the map
  localparam int DEPTH = MAP_PIXELS / DELAY_STAGES;

  // Stage k input at index k, chain output at the end
  logic   stage_valid [DELAY_STAGES+1];
  pixel_t stage_data  [DELAY_STAGES+1];

  // Uneven split would leave the chain short of one map
  if (MAP_PIXELS % DELAY_STAGES != 0) begin : g_bad_split
    $error("MAP_PIXELS %0d not divisible by DELAY_STAGES %0d",
           MAP_PIXELS, DELAY_STAGES);
  end

  assign stage_valid[0] = valid_in;
  assign stage_data[0]  = data_in;

  //////////////////////////////
  // Line buffer chain
  //////////////////////////////

  // Next stage only shifts when the previous one emits
  for (genvar k = 0; k < DELAY_STAGES; k++) begin : g_stage
    line_buffer #(
      .DEPTH(DEPTH)
    ) line_buffer_inst (
      .clk      (clk),
      .reset    (reset),
      .valid_in (stage_valid[k]),
      .data_in  (stage_data[k]),
      .valid_out(stage_valid[k+1]),
      .data_out (stage_data[k+1])
    );
  end

  assign valid_out = stage_valid[DELAY_STAGES];
  assign data_out  = stage_data[DELAY_STAGES];

endmodule

/* hw/cnn_concat_merge.sv */
module cnn_concat_merge (
  input  logic                    clk,
  input  logic                    reset,
  // Branch 2, straight from the input
  input  logic                    in_valid_no2,
  input  cnn_types_pkg::pixel_t   in_no2,
  // Branch 1 after one map of delay
  input  logic                    dly_valid,
  input  cnn_types_pkg::pixel_t   dly_data,
  concat_stream_if.producer       stream
);
  import cnn_types_pkg::*;

  logic   both_valid;
  logic   any_valid;
  pixel_t sel_data;
  src_t   sel_src;

  //////////////////////////////
  // Priority select
  //////////////////////////////

  assign both_valid = in_valid_no2 && dly_valid;
  assign any_valid  = in_valid_no2 || dly_valid;

  // Branch 2 wins, branch 1 only fills the gaps
  always_comb begin
    if (in_valid_no2) begin
      sel_data = in_no2;
      sel_src  = SRC_BRANCH2;
    end else begin
      sel_data = dly_data;
      sel_src  = SRC_BRANCH1;
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      stream.valid     <= 1'b0;
      stream.collision <= 1'b0;
      stream.src       <= SRC_BRANCH1;
    end else begin
      stream.valid     <= any_valid;
      // Delayed branch-1 pixel dropped here
      stream.collision <= both_valid;
      stream.src       <= sel_src;
    end
  end

  // Payload, held through idle cycles
  always_ff @(posedge clk) begin
    if (any_valid) begin
      stream.data <= sel_data;
    end
  end

  // A collision always carries the winning branch-2 pixel
  a_collision_has_pixel : assert property (
    @(posedge clk) disable iff (reset) stream.collision |-> stream.valid
  );

endmodule

/* hw/cnn_concat_out.sv */
module cnn_concat_out #(
  parameter int MAP_PIXELS = cnn_geom_pkg::MAP_PIXELS_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  concat_stream_if.consumer     stream,
  output cnn_types_pkg::pixel_t out,
  output logic                  valid_out,
  output logic                  out_last,
  output cnn_types_pkg::src_t   out_src,
  output logic                  collision
);
  import cnn_types_pkg::*;

  // One concatenated map is both branches back to back
  localparam int CONCAT_PIXELS = 2 * MAP_PIXELS;
  localparam int CNT_W         = $clog2(CONCAT_PIXELS);

  logic [CNT_W-1:0] pixel_cnt;
  logic             at_last;

  assign at_last = (pixel_cnt == CNT_W'(CONCAT_PIXELS - 1));

  //////////////////////////////
  // Map framing
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      pixel_cnt <= '0;
      valid_out <= 1'b0;
      out_last  <= 1'b0;
      collision <= 1'b0;
      out_src   <= SRC_BRANCH1;
    end else begin
      valid_out <= stream.valid;
      collision <= stream.collision;
      out_src   <= stream.src;
      // Last flag rides with the pixel that completes the map
      out_last  <= stream.valid && at_last;
      if (stream.valid) begin
        pixel_cnt <= at_last ? '0 : pixel_cnt + 1'b1;
      end
    end
  end

  // Data register, no reset
  always_ff @(posedge clk) begin
    if (stream.valid) begin
      out <= stream.data;
    end
  end

  // Framing never marks an empty cycle
  a_last_with_valid : assert property (
    @(posedge clk) disable iff (reset) out_last |-> valid_out
  );

endmodule

/* hw/cnn_concat_top.sv */
module cnn_concat_top #(
  parameter int MAP_PIXELS   = cnn_geom_pkg::MAP_PIXELS_DEFAULT,
  parameter int DELAY_STAGES = cnn_geom_pkg::DELAY_STAGES_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset,
  // Branch 1, delayed by one map
  input  logic                  valid_in_no1,
  input  cnn_types_pkg::pixel_t in_no1,
  // Branch 2, passed straight through
  input  logic                  valid_in_no2,
  input  cnn_types_pkg::pixel_t in_no2,
  // Concatenated stream
  output cnn_types_pkg::pixel_t out,
  output logic                  valid_out,
  output logic                  out_last,
  output cnn_types_pkg::src_t   out_src,
  output logic                  collision
);
  import cnn_types_pkg::*;

  logic   dly_valid;
  pixel_t dly_data;

  concat_stream_if stream_if ();

  //////////////////////////////
  // Input side
  //////////////////////////////

  cnn_concat_delay #(
    .MAP_PIXELS  (MAP_PIXELS),
    .DELAY_STAGES(DELAY_STAGES)
  ) delay_inst (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in_no1),
    .data_in  (in_no1),
    .valid_out(dly_valid),
    .data_out (dly_data)
  );

  // Merge, one cycle
  cnn_concat_merge merge_inst (
    .clk         (clk),
    .reset       (reset),
    .in_valid_no2(valid_in_no2),
    .in_no2      (in_no2),
    .dly_valid   (dly_valid),
    .dly_data    (dly_data),
    .stream      (stream_if.producer)
  );

  // Output side, one more cycle
  cnn_concat_out #(
    .MAP_PIXELS(MAP_PIXELS)
  ) out_inst (
    .clk      (clk),
    .reset    (reset),
    .stream   (stream_if.consumer),
    .out      (out),
    .valid_out(valid_out),
    .out_last (out_last),
    .out_src  (out_src),
    .collision(collision)
  );

endmodule

/* dv/cnn_concat_checker.sv */
module cnn_concat_checker (
  input  logic                  clk,
  // DUT outputs
  input  cnn_types_pkg::pixel_t out,
  input  logic                  valid_out,
  input  logic                  out_last,
  input  cnn_types_pkg::src_t   out_src,
  input  logic                  collision,
  // Expected columns, aligned with the stimulus row
  input  logic                  exp_valid,
  input  cnn_types_pkg::pixel_t exp_out,
  input  logic                  exp_last,
  input  cnn_types_pkg::src_t   exp_src,
  input  logic                  exp_coll,
  output int                    error_count,
  output int                    check_count
);
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_types_pkg::*;

  typedef struct packed {
    logic   valid;
    pixel_t data;
    logic   last;
    src_t   src;
    logic   coll;
  } expect_t;

  expect_t exp_now;
  expect_t exp_d1 = '0;
  expect_t exp_d2 = '0;
  logic    armed  = 1'b0;

  assign exp_now = {exp_valid, exp_out, exp_last, exp_src, exp_coll};

  // Two cycles of DUT latency
  always @(posedge clk) begin
    exp_d1 <= exp_now;
    exp_d2 <= exp_d1;
    armed  <= 1'b1;
  end

  task automatic compare(string name, logic [15:0] actual, logic [15:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: expected %h, got %h at %0t", name, expected, actual, $time);
    end
  endtask

  //////////////////////////////
  // Compare, mid-cycle
  //////////////////////////////

  always @(negedge clk) begin
    if (armed) begin
      compare("valid_out", 16'(valid_out), 16'(exp_d2.valid));
      compare("out_last", 16'(out_last), 16'(exp_d2.last));
      compare("collision", 16'(collision), 16'(exp_d2.coll));
      // Payload and tag only mean something with valid
      if (exp_d2.valid) begin
        compare("out", out, exp_d2.data);
        compare("out_src", 16'(out_src), 16'(exp_d2.src));
      end
    end
  end

endmodule

/* dv/tb_cnn_concat.sv */
module tb_cnn_concat;
  timeunit 1ns;
  timeprecision 1ps;
  import cnn_types_pkg::*;

  localparam int MAP_PIXELS   = 8;
  localparam int DELAY_STAGES = 2;
  localparam int NUM_VECTORS  = 35;
  // Words per vector row
  localparam int WORDS        = 9;
  localparam int MAX_CYCLES   = NUM_VECTORS + 20;

  logic   clk = 1'b0;
  logic   reset;
  logic   valid_in_no1;
  pixel_t in_no1;
  logic   valid_in_no2;
  pixel_t in_no2;
  pixel_t out;
  logic   valid_out;
  logic   out_last;
  src_t   out_src;
  logic   collision;

  // Expected response for the row driven now
  logic   exp_valid;
  pixel_t exp_out;
  logic   exp_last;
  src_t   exp_src;
  logic   exp_coll;

  logic [15:0] vec_mem [NUM_VECTORS*WORDS];
  int          bad_rows;
  int          error_count;
  int          check_count;
  int          cycle_count = 0;

  always #2 clk = ~clk;

  cnn_concat_top #(
    .MAP_PIXELS  (MAP_PIXELS),
    .DELAY_STAGES(DELAY_STAGES)
  ) cnn_concat_top_inst (
    .clk         (clk),
    .reset       (reset),
    .valid_in_no1(valid_in_no1),
    .in_no1      (in_no1),
    .valid_in_no2(valid_in_no2),
    .in_no2      (in_no2),
    .out         (out),
    .valid_out   (valid_out),
    .out_last    (out_last),
    .out_src     (out_src),
    .collision   (collision)
  );

  cnn_concat_checker checker_inst (
    .clk        (clk),
    .out        (out),
    .valid_out  (valid_out),
    .out_last   (out_last),
    .out_src    (out_src),
    .collision  (collision),
    .exp_valid  (exp_valid),
    .exp_out    (exp_out),
    .exp_last   (exp_last),
    .exp_src    (exp_src),
    .exp_coll   (exp_coll),
    .error_count(error_count),
    .check_count(check_count)
  );

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  initial begin
    int base;
    reset        = 1'b1;
    valid_in_no1 = 1'b0;
    in_no1       = '0;
    valid_in_no2 = 1'b0;
    in_no2       = '0;
    exp_valid    = 1'b0;
    exp_out      = '0;
    exp_last     = 1'b0;
    exp_src      = SRC_BRANCH1;
    exp_coll     = 1'b0;
    bad_rows     = 0;
    // Flag columns can never hold this fill
    for (int a = 0; a < NUM_VECTORS * WORDS; a++) begin
      vec_mem[a] = 16'h8000 | 16'(a);
    end
    $readmemh("dv/concat_vectors.txt", vec_mem);
    for (int r = 0; r < NUM_VECTORS; r++) begin
      base = r * WORDS;
      if (vec_mem[base] > 1 || vec_mem[base+2] > 1 || vec_mem[base+4] > 1 ||
          vec_mem[base+6] > 1 || vec_mem[base+7] > 1 || vec_mem[base+8] > 1) begin
        bad_rows++;
      end
    end
    if (bad_rows != 0) begin
      $display("Vector file missing or malformed, %0d bad rows", bad_rows);
    end

    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // One row per cycle, expected values travel with it
    for (int r = 0; r < NUM_VECTORS; r++) begin
      base = r * WORDS;
      valid_in_no1 <= vec_mem[base][0];
      in_no1       <= vec_mem[base+1];
      valid_in_no2 <= vec_mem[base+2][0];
      in_no2       <= vec_mem[base+3];
      exp_valid    <= vec_mem[base+4][0];
      exp_out      <= vec_mem[base+5];
      exp_last     <= vec_mem[base+6][0];
      exp_src      <= src_t'(vec_mem[base+7][0]);
      exp_coll     <= vec_mem[base+8][0];
      @(posedge clk);
    end

    // Drain the pipeline with idle cycles
    valid_in_no1 <= 1'b0;
    valid_in_no2 <= 1'b0;
    exp_valid    <= 1'b0;
    exp_last     <= 1'b0;
    exp_coll     <= 1'b0;
    repeat (3) @(posedge clk);

    $display("Checks %0d, value errors %0d, bad vector rows %0d",
             check_count, error_count, bad_rows);
    if (error_count == 0 && bad_rows == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, stimulus never completed", MAX_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

/* dv/concat_vectors.txt */
// v1 in_no1 v2 in_no2 | exp: valid out last src collision (output two cycles later)
// Map of 8 pixels per branch, chain of 2 line buffers of depth 4
// First branch-1 map A together with branch-2 map B, idle cycles inside
0 0000 0 0000 0 0000 0 0 0
1 1a00 1 2b00 1 2b00 0 1 0
1 1a01 1 2b01 1 2b01 0 1 0
1 1a02 1 2b02 1 2b02 0 1 0
1 1a03 1 2b03 1 2b03 0 1 0
0 0000 0 0000 0 0000 0 0 0
1 1a04 1 2b04 1 2b04 0 1 0
1 1a05 1 2b05 1 2b05 0 1 0
1 1a06 1 2b06 1 2b06 0 1 0
1 1a07 1 2b07 1 2b07 0 1 0
// Branch-1 map C pushes map A out, A7 closes the first concatenated map
1 1c00 0 0000 1 1a00 0 0 0
1 1c01 0 0000 1 1a01 0 0 0
1 1c02 0 0000 1 1a02 0 0 0
1 1c03 0 0000 1 1a03 0 0 0
0 0000 0 0000 0 0000 0 0 0
1 1c04 0 0000 1 1a04 0 0 0
1 1c05 0 0000 1 1a05 0 0 0
1 1c06 0 0000 1 1a06 0 0 0
1 1c07 0 0000 1 1a07 1 0 0
// E0 emits C0 while D0 arrives, C0 is lost
1 1e00 1 2d00 1 2d00 0 1 1
1 1e01 0 0000 1 1c01 0 0 0
1 1e02 0 0000 1 1c02 0 0 0
1 1e03 0 0000 1 1c03 0 0 0
1 1e04 0 0000 1 1c04 0 0 0
1 1e05 0 0000 1 1c05 0 0 0
1 1e06 0 0000 1 1c06 0 0 0
1 1e07 0 0000 1 1c07 0 0 0
// Rest of map D, then E0 is the sixteenth pixel
0 0000 1 2d01 1 2d01 0 1 0
0 0000 1 2d02 1 2d02 0 1 0
0 0000 1 2d03 1 2d03 0 1 0
0 0000 1 2d04 1 2d04 0 1 0
0 0000 1 2d05 1 2d05 0 1 0
0 0000 1 2d06 1 2d06 0 1 0
0 0000 1 2d07 1 2d07 0 1 0
1 1f00 0 0000 1 1e00 1 0 0

/* list.f */
hw/cnn_types_pkg.sv
hw/cnn_geom_pkg.sv
hw/concat_stream_if.sv
hw/line_buffer.sv
hw/cnn_concat_delay.sv
hw/cnn_concat_merge.sv
hw/cnn_concat_out.sv
hw/cnn_concat_top.sv
dv/cnn_concat_checker.sv
dv/tb_cnn_concat.sv

/* Makefile */
TOP = tb_cnn_concat
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
